// ==== hw/egress_pkg.sv ====
////////////////////////////////////////////////////////////
// Egress router shared definitions
////////////////////////////////////////////////////////////

package egress_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes

    localparam int NUM_PORTS     = 4;
    localparam int PORT_ID_W     = 2;
    localparam int IN_BYTES      = 8;
    localparam int OUT_BYTES     = 4;
    localparam int FIFO_DEPTH    = 16;
    localparam int MAX_PKT_WORDS = 8;
    localparam int CNT_W         = 32;

    // Buffer pointer and fill level widths
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    ////////////////////////////////////////////////////////////
    // Types

    typedef logic [PORT_ID_W-1:0]   port_id_t;
    typedef logic [IN_BYTES*8-1:0]  in_word_t;
    typedef logic [OUT_BYTES*8-1:0] out_beat_t;

    // Demux packet state, held from the first word to last
    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        DISCARD
    } demux_state_t;

    // Narrower beat state, which half is on the output
    typedef enum logic [1:0] {
        EMPTY,
        LOW_HALF,
        HIGH_HALF
    } narrow_state_t;

endpackage

// ==== hw/word_stream_if.sv ====
////////////////////////////////////////////////////////////
// Word stream interface
////////////////////////////////////////////////////////////

interface word_stream_if import egress_pkg::*; ();

    in_word_t            data;
    logic [IN_BYTES-1:0] keep;
    logic                last;
    logic                valid;
    logic                ready;

    // Producer side
    modport src (output data, output keep, output last, output valid, input ready);

    // Consumer side
    modport dst (input data, input keep, input last, input valid, output ready);

endinterface

// ==== hw/egress_demux.sv ====
////////////////////////////////////////////////////////////
// Egress packet demux
////////////////////////////////////////////////////////////

module egress_demux import egress_pkg::*; (
    input  logic                 core_clk_ifc,
    input  logic                 rst,
    input  logic                 in_valid,
    input  in_word_t             in_data,
    input  logic [IN_BYTES-1:0]  in_keep,
    input  logic                 in_last,
    input  port_id_t             in_port,
    input  logic [NUM_PORTS-1:0] port_enable,
    input  logic [NUM_PORTS-1:0] room,
    output logic [NUM_PORTS-1:0] buf_full_drop,
    word_stream_if.src           to_fifo [NUM_PORTS]
);

    demux_state_t state;
    port_id_t     cur_port;
    logic         start_ok;
    port_id_t     sel_port;
    logic         fwd;

    // Start check on the first word, port enabled and room for a full packet
    assign start_ok = port_enable[in_port] & room[in_port];
    assign sel_port = (state == IDLE) ? in_port : cur_port;
    assign fwd      = in_valid && ((state == FORWARD) || (state == IDLE && start_ok));

    ////////////////////////////////////////////////////////////
    // Per-port write strobes

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        assign to_fifo[p].data  = in_data;
        assign to_fifo[p].keep  = in_keep;
        assign to_fifo[p].last  = in_last;
        assign to_fifo[p].valid = fwd && (sel_port == port_id_t'(p));

        // Drop flag only for enabled ports, a disabled port discards quietly
        assign buf_full_drop[p] = in_valid && (state == IDLE)
                                  && (in_port == port_id_t'(p))
                                  && port_enable[p] && !room[p];
    end

    ////////////////////////////////////////////////////////////
    // Packet state

    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            state    <= IDLE;
            cur_port <= '0;
        end else if (in_valid) begin
            case (state)
                IDLE: begin
                    cur_port <= in_port;
                    // Single word packets never leave IDLE
                    if (!in_last) begin
                        state <= start_ok ? FORWARD : DISCARD;
                    end
                end
                default: begin
                    if (in_last) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== hw/packet_fifo.sv ====
////////////////////////////////////////////////////////////
// Per-port packet buffer
////////////////////////////////////////////////////////////

module packet_fifo import egress_pkg::*; (
    input  logic       core_clk_ifc,
    input  logic       rst,
    word_stream_if.dst wr,
    word_stream_if.src rd,
    output logic       room
);

    in_word_t            mem_data [FIFO_DEPTH];
    logic [IN_BYTES-1:0] mem_keep [FIFO_DEPTH];
    logic                mem_last [FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  push;
    logic                  pop;

    assign wr.ready = (count != FIFO_CNT_W'(FIFO_DEPTH));
    assign push     = wr.valid && wr.ready;
    assign pop      = rd.valid && rd.ready;

    // Oldest entry is always on the read side
    assign rd.valid = (count != '0);
    assign rd.data  = mem_data[rd_ptr];
    assign rd.keep  = mem_keep[rd_ptr];
    assign rd.last  = mem_last[rd_ptr];

    // Enough free entries left for a maximum size packet
    assign room = (count <= FIFO_CNT_W'(FIFO_DEPTH - MAX_PKT_WORDS));

    always_ff @(posedge core_clk_ifc) begin
        if (push) begin
            mem_data[wr_ptr] <= wr.data;
            mem_keep[wr_ptr] <= wr.keep;
            mem_last[wr_ptr] <= wr.last;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hw/width_narrower.sv ====
////////////////////////////////////////////////////////////
// 64 to 32 bit width narrower
////////////////////////////////////////////////////////////

module width_narrower import egress_pkg::*; (
    input  logic                 core_clk_ifc,
    input  logic                 rst,
    word_stream_if.dst           word_in,
    output out_beat_t            out_data,
    output logic [OUT_BYTES-1:0] out_keep,
    output logic                 out_last,
    output logic                 out_valid,
    input  logic                 out_ready
);

    narrow_state_t       state;
    in_word_t            word_data;
    logic [IN_BYTES-1:0] word_keep;
    logic                word_last;
    logic                skip_high;
    logic                final_beat;
    logic                beat_done;
    logic                take;

    // Short last word, upper half carries no bytes
    assign skip_high  = word_last && (word_keep[OUT_BYTES +: OUT_BYTES] == '0);
    assign final_beat = (state == HIGH_HALF) || (state == LOW_HALF && skip_high);

    assign out_valid = (state != EMPTY);
    assign out_data  = (state == HIGH_HALF) ? word_data[OUT_BYTES*8 +: OUT_BYTES*8]
                                            : word_data[0 +: OUT_BYTES*8];
    assign out_keep  = (state == HIGH_HALF) ? word_keep[OUT_BYTES +: OUT_BYTES]
                                            : word_keep[0 +: OUT_BYTES];
    assign out_last  = word_last && final_beat;

    assign beat_done     = out_valid && out_ready;
    // Next word can load as the last pending beat leaves
    assign word_in.ready = (state == EMPTY) || (beat_done && final_beat);
    assign take          = word_in.valid && word_in.ready;

    always_ff @(posedge core_clk_ifc) begin
        if (take) begin
            word_data <= word_in.data;
            word_keep <= word_in.keep;
            word_last <= word_in.last;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            state <= EMPTY;
        end else if (take) begin
            state <= LOW_HALF;
        end else if (beat_done) begin
            state <= final_beat ? EMPTY : HIGH_HALF;
        end
    end

endmodule

// ==== hw/egress_counters.sv ====
////////////////////////////////////////////////////////////
// Egress packet counters
////////////////////////////////////////////////////////////

module egress_counters import egress_pkg::*; (
    input  logic                 core_clk_ifc,
    input  logic                 rst,
    input  logic [NUM_PORTS-1:0] out_last,
    input  logic [NUM_PORTS-1:0] out_valid,
    input  logic [NUM_PORTS-1:0] out_ready,
    input  logic [NUM_PORTS-1:0] cnt_clear,
    output logic [CNT_W-1:0]     pkt_cnt [NUM_PORTS]
);

    logic [NUM_PORTS-1:0] pkt_done;

    // A packet is done when its last beat transfers
    assign pkt_done = out_valid & out_ready & out_last;

    always_ff @(posedge core_clk_ifc) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            // Clear wins over a same cycle increment
            if (rst || cnt_clear[p]) begin
                pkt_cnt[p] <= '0;
            end else if (pkt_done[p]) begin
                pkt_cnt[p] <= pkt_cnt[p] + 1'b1;
            end
        end
    end

endmodule

// ==== hw/egress_router_top.sv ====
////////////////////////////////////////////////////////////
// Egress router top level
////////////////////////////////////////////////////////////

module egress_router_top import egress_pkg::*; (
    input  logic                 core_clk_ifc,
    input  logic                 rst,
    // Input word stream
    input  logic                 in_valid,
    input  in_word_t             in_data,
    input  logic [IN_BYTES-1:0]  in_keep,
    input  logic                 in_last,
    input  port_id_t             in_port,
    // Per-port control and status
    output logic [NUM_PORTS-1:0] buf_ready,
    input  logic [NUM_PORTS-1:0] port_enable,
    output logic [NUM_PORTS-1:0] buf_full_drop,
    // Per-port output streams
    output out_beat_t            out_data [NUM_PORTS],
    output logic [OUT_BYTES-1:0] out_keep [NUM_PORTS],
    output logic [NUM_PORTS-1:0] out_last,
    output logic [NUM_PORTS-1:0] out_valid,
    input  logic [NUM_PORTS-1:0] out_ready,
    // Counters
    input  logic [NUM_PORTS-1:0] cnt_clear,
    output logic [CNT_W-1:0]     pkt_cnt [NUM_PORTS]
);

    word_stream_if demux_to_fifo [NUM_PORTS] ();
    word_stream_if fifo_to_narrow [NUM_PORTS] ();

    egress_demux u_demux (
        .core_clk_ifc  (core_clk_ifc),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_keep       (in_keep),
        .in_last       (in_last),
        .in_port       (in_port),
        .port_enable   (port_enable),
        .room          (buf_ready),
        .buf_full_drop (buf_full_drop),
        .to_fifo       (demux_to_fifo)
    );

    ////////////////////////////////////////////////////////////
    // Buffer lanes

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_fifo
        packet_fifo u_fifo (
            .core_clk_ifc (core_clk_ifc),
            .rst          (rst),
            .wr           (demux_to_fifo[p]),
            .rd           (fifo_to_narrow[p]),
            .room         (buf_ready[p])
        );
    end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_narrow
        width_narrower u_narrow (
            .core_clk_ifc (core_clk_ifc),
            .rst          (rst),
            .word_in      (fifo_to_narrow[p]),
            .out_data     (out_data[p]),
            .out_keep     (out_keep[p]),
            .out_last     (out_last[p]),
            .out_valid    (out_valid[p]),
            .out_ready    (out_ready[p])
        );
    end

    egress_counters u_counters (
        .core_clk_ifc (core_clk_ifc),
        .rst          (rst),
        .out_last     (out_last),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .cnt_clear    (cnt_clear),
        .pkt_cnt      (pkt_cnt)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////
// Testbench clock source
////////////////////////////////////////////////////////////

module tb_clock_gen #(
    parameter int HALF_PERIOD = 4
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;

    always #(HALF_PERIOD) clk = ~clk;

endmodule

// ==== verification/egress_router_properties.sv ====
////////////////////////////////////////////////////////////
// Egress router assertions
////////////////////////////////////////////////////////////

module egress_router_properties import egress_pkg::*; (
    input logic                 core_clk_ifc,
    input logic                 rst,
    input logic                 in_valid,
    input logic                 in_last,
    input logic [NUM_PORTS-1:0] buf_full_drop,
    input logic [NUM_PORTS-1:0] out_valid,
    input logic [NUM_PORTS-1:0] out_ready,
    input logic [NUM_PORTS-1:0] out_last,
    input out_beat_t            out_data [NUM_PORTS]
);
    timeunit 1ns;
    timeprecision 100ps;

    logic in_pkt;

    // Set between the first and the last word of an input packet
    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            in_pkt <= 1'b0;
        end else if (in_valid) begin
            in_pkt <= !in_last;
        end
    end

    // A stalled beat keeps its valid, data and last
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_hold
        a_beat_hold: assert property (@(posedge core_clk_ifc) disable iff (rst)
            out_valid[p] && !out_ready[p] |=>
                out_valid[p] && $stable(out_data[p]) && $stable(out_last[p]))
            else $error("port %0d output beat changed while stalled", p);
    end

    // Drop decision only on the first word of a packet
    a_drop_needs_input: assert property (@(posedge core_clk_ifc) disable iff (rst)
        (buf_full_drop != '0) |-> in_valid && !in_pkt)
        else $error("buf_full_drop pulsed without a packet start word");

    a_reset_clears_out: assert property (@(posedge core_clk_ifc)
        rst |=> (out_valid == '0))
        else $error("out_valid high in the cycle after reset");

endmodule

bind egress_router_top egress_router_properties u_props (
    .core_clk_ifc  (core_clk_ifc),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_last       (in_last),
    .buf_full_drop (buf_full_drop),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_last      (out_last),
    .out_data      (out_data)
);

// ==== verification/egress_router_tb.sv ====
////////////////////////////////////////////////////////////
// Egress router directed testbench
////////////////////////////////////////////////////////////

module egress_router_tb import egress_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED = 32'h4e29bd35;
    // Upper bound of packets over all tests with at most MAX_PKT_WORDS words each
    localparam int MAX_PKTS        = 42;
    localparam int WATCHDOG_CYCLES = MAX_PKTS * MAX_PKT_WORDS * 40 + 2000;

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    in_word_t             in_data;
    logic [IN_BYTES-1:0]  in_keep;
    logic                 in_last;
    port_id_t             in_port;
    logic [NUM_PORTS-1:0] buf_ready;
    logic [NUM_PORTS-1:0] port_enable;
    logic [NUM_PORTS-1:0] buf_full_drop;
    out_beat_t            out_data [NUM_PORTS];
    logic [OUT_BYTES-1:0] out_keep [NUM_PORTS];
    logic [NUM_PORTS-1:0] out_last;
    logic [NUM_PORTS-1:0] out_valid;
    logic [NUM_PORTS-1:0] out_ready;
    logic [NUM_PORTS-1:0] cnt_clear;
    logic [CNT_W-1:0]     pkt_cnt [NUM_PORTS];

    // Expected bytes and packet lengths per port
    logic [7:0]           byte_q [NUM_PORTS][$];
    int                   len_q [NUM_PORTS][$];
    int                   rem [NUM_PORTS];
    int                   drop_cnt [NUM_PORTS];
    // Packets accepted per port since the last clear
    int                   exp_cnt [NUM_PORTS];
    logic [31:0]          rng_state;
    logic [31:0]          bp_state;
    logic                 bp_mode;
    logic [NUM_PORTS-1:0] ready_mask;
    string                cur_test;
    int                   err_count;
    int                   test_errs;
    int                   n_pass;
    int                   n_fail;

    tb_clock_gen u_clk (.clk(clk));

    egress_router_top UUT (
        .core_clk_ifc (clk),          .rst           (rst),
        .in_valid     (in_valid),     .in_data       (in_data),
        .in_keep      (in_keep),      .in_last       (in_last),
        .in_port      (in_port),      .buf_ready     (buf_ready),
        .port_enable  (port_enable),  .buf_full_drop (buf_full_drop),
        .out_data     (out_data),     .out_keep      (out_keep),
        .out_last     (out_last),     .out_valid     (out_valid),
        .out_ready    (out_ready),    .cnt_clear     (cnt_clear),
        .pkt_cnt      (pkt_cnt)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic int rand_len();
        return int'(next_rand() % (MAX_PKT_WORDS * IN_BYTES)) + 1;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERR %s: %s expected %0h actual %0h", cur_test, what, exp, act);
        err_count++;
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitor and back-pressure

    // Each beat carries the next min(4, remaining) bytes of its packet
    task automatic check_beat(input int p);
        int                   n;
        logic [OUT_BYTES-1:0] exp_keep;
        logic                 exp_last;
        logic [7:0]           exp_b;
        if (rem[p] == 0) begin
            if (len_q[p].size() == 0) begin
                $display("Unexpected output beat on port %0d in %s", p, cur_test);
                err_count++;
                return;
            end
            rem[p] = len_q[p].pop_front();
        end
        n        = (rem[p] < OUT_BYTES) ? rem[p] : OUT_BYTES;
        exp_keep = OUT_BYTES'((1 << n) - 1);
        exp_last = (rem[p] == n);
        if (out_keep[p] !== exp_keep) begin
            report_mismatch($sformatf("port %0d keep", p), 32'(exp_keep), 32'(out_keep[p]));
        end
        if (out_last[p] !== exp_last) begin
            report_mismatch($sformatf("port %0d last", p), 32'(exp_last), 32'(out_last[p]));
        end
        for (int i = 0; i < n; i++) begin
            exp_b = byte_q[p].pop_front();
            if (out_data[p][i*8 +: 8] !== exp_b) begin
                report_mismatch($sformatf("port %0d byte", p), 32'(exp_b),
                                32'(out_data[p][i*8 +: 8]));
            end
        end
        rem[p] -= n;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (buf_full_drop[p]) drop_cnt[p]++;
                if (out_valid[p] && out_ready[p]) check_beat(p);
            end
        end
    end

    always @(posedge clk) begin
        if (bp_mode) begin
            bp_state = xorshift(bp_state);
            out_ready <= bp_state[NUM_PORTS-1:0];
        end else begin
            out_ready <= ready_mask;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers

    task automatic send_packet(input int port, input int nbytes, input bit accept);
        int                  nwords;
        int                  b;
        logic [31:0]         r;
        in_word_t            word;
        logic [IN_BYTES-1:0] keep;
        nwords = (nbytes + IN_BYTES - 1) / IN_BYTES;
        // Sender waits for room before an accepted packet
        @(negedge clk);
        while (accept && !buf_ready[port]) @(negedge clk);
        if (accept) begin
            len_q[port].push_back(nbytes);
            exp_cnt[port]++;
        end
        for (int w = 0; w < nwords; w++) begin
            word = '0;
            keep = '0;
            for (int i = 0; i < IN_BYTES; i++) begin
                b = w * IN_BYTES + i;
                if (b < nbytes) begin
                    r = next_rand();
                    word[i*8 +: 8] = r[7:0];
                    keep[i] = 1'b1;
                    if (accept) byte_q[port].push_back(r[7:0]);
                end
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_data  <= word;
            in_keep  <= keep;
            in_last  <= (w == nwords - 1);
            in_port  <= port_id_t'(port);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        in_last  <= 1'b0;
    endtask

    task automatic wait_drain();
        bit busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = 1'b0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (len_q[p].size() != 0 || rem[p] != 0) busy = 1'b1;
            end
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic pulse_clear(input logic [NUM_PORTS-1:0] mask);
        @(posedge clk);
        cnt_clear <= mask;
        @(posedge clk);
        cnt_clear <= '0;
        @(negedge clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (mask[p]) exp_cnt[p] = 0;
        end
    endtask

    task automatic check_count(input int p, input int exp);
        if (pkt_cnt[p] !== CNT_W'(exp)) begin
            report_mismatch($sformatf("pkt_cnt[%0d]", p), 32'(exp), 32'(pkt_cnt[p]));
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = err_count;
    endtask

    task automatic finish_test();
        if (err_count == test_errs) begin
            n_pass++;
            $display("%s: PASS", cur_test);
        end else begin
            n_fail++;
            $display("%s: FAIL with %0d errors", cur_test, err_count - test_errs);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_routing();
        start_test("routing");
        for (int p = 0; p < NUM_PORTS; p++) send_packet(p, rand_len(), 1'b1);
        wait_drain();
        finish_test();
    endtask

    task automatic test_backpressure();
        start_test("backpressure");
        bp_mode = 1'b1;
        for (int k = 0; k < 12; k++) send_packet(int'(next_rand() % NUM_PORTS), rand_len(), 1'b1);
        wait_drain();
        bp_mode = 1'b0;
        finish_test();
    endtask

    task automatic test_port_disable();
        start_test("port_disable");
        @(posedge clk);
        port_enable <= 4'b1011;
        send_packet(0, rand_len(), 1'b1);
        send_packet(2, rand_len(), 1'b0);
        send_packet(1, rand_len(), 1'b1);
        wait_drain();
        // Discarded packet leaves the port 2 count where it was
        for (int p = 0; p < NUM_PORTS; p++) check_count(p, exp_cnt[p]);
        @(posedge clk);
        port_enable <= '1;
        finish_test();
    endtask

    task automatic test_counters();
        start_test("counters");
        pulse_clear('1);
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int k = 0; k <= p; k++) send_packet(p, rand_len(), 1'b1);
        end
        wait_drain();
        for (int p = 0; p < NUM_PORTS; p++) check_count(p, p + 1);
        pulse_clear(4'b0010);
        for (int p = 0; p < NUM_PORTS; p++) check_count(p, (p == 1) ? 0 : p + 1);
        finish_test();
    endtask

    task automatic test_full_drop();
        int drops_before [NUM_PORTS];
        int sent;
        start_test("full_drop");
        @(negedge clk);
        ready_mask = 4'b0111;
        sent = 0;
        @(negedge clk);
        while (buf_ready[3] && sent < 12) begin
            send_packet(3, rand_len(), 1'b1);
            sent++;
            @(negedge clk);
        end
        if (buf_ready[3]) begin
            $display("%s: buf_ready of port 3 never fell", cur_test);
            err_count++;
        end
        drops_before = drop_cnt;
        send_packet(3, rand_len(), 1'b0);
        @(negedge clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (drop_cnt[p] - drops_before[p] != ((p == 3) ? 1 : 0)) begin
                report_mismatch($sformatf("drop pulses on port %0d", p),
                                (p == 3) ? 1 : 0, drop_cnt[p] - drops_before[p]);
            end
        end
        ready_mask = '1;
        wait_drain();
        finish_test();
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog

    initial begin
        rng_state   = SEED;
        bp_state    = ~SEED;
        bp_mode     = 1'b0;
        ready_mask  = '1;
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_data     = '0;
        in_keep     = '0;
        in_last     = 1'b0;
        in_port     = '0;
        port_enable = '1;
        out_ready   = '1;
        cnt_clear   = '0;
        err_count   = 0;
        n_pass      = 0;
        n_fail      = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_routing();
        test_backpressure();
        test_port_disable();
        test_counters();
        test_full_drop();
        $display("Tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, err_count);
        if (n_fail == 0 && err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles in %s", WATCHDOG_CYCLES, cur_test);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== all.f ====
hw/egress_pkg.sv
hw/word_stream_if.sv
hw/egress_demux.sv
hw/packet_fifo.sv
hw/width_narrower.sv
hw/egress_counters.sv
hw/egress_router_top.sv
verification/tb_clock_gen.sv
verification/egress_router_properties.sv
verification/egress_router_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= egress_router_tb
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f all.f
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
